//--- lb_config_regs.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module lb_config_regs #(
	parameter logic [7:0] misc_config_default = 8'h00
) (
	input  logic            clk,
	input  logic            rst_n,
	input  lb_pkg::lb_req_t req,
	output lb_pkg::lb_cfg_t cfg,
	output logic            mirror_we
);

	logic                    local_write;
	logic [4:0]              wr_offset;
	logic [`LB_PAGE_W-1:0]   wr_page;

	// --------------------
	// Write decode
	// --------------------
	assign wr_page   = req.addr[`LB_ADDR_W-1 -: `LB_PAGE_W];
	assign wr_offset = req.addr[4:0];

	// Any write into the local page whether its offset is decoded or not
	assign local_write = req.strobe && !req.rd && (wr_page == `LB_PAGE_LOCAL);

	// The mirror takes every local write at the same edge as the registers
	assign mirror_we = local_write;

	// --------------------
	// Steering registers
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.led_user_mode <= 2'b00;
			cfg.led1_df       <= 8'h00;
			cfg.led2_df       <= 8'h00;
			// Upper receive bank selected out of reset
			cfg.rx_mac_hbank  <= 1'b1;
			cfg.misc_config   <= misc_config_default;
		end else if (local_write) begin
			case (wr_offset)
				`LB_REG_LED_USER: begin
					cfg.led_user_mode <= req.wdata[1:0];
				end
				`LB_REG_LED1_DF: begin
					cfg.led1_df <= req.wdata[7:0];
				end
				`LB_REG_LED2_DF: begin
					cfg.led2_df <= req.wdata[7:0];
				end
				`LB_REG_RX_HBANK: begin
					cfg.rx_mac_hbank <= req.wdata[0];
				end
				`LB_REG_MISC: begin
					cfg.misc_config <= req.wdata[7:0];
				end
				default: begin
					// Mirror only
				end
			endcase
		end
	end

	// --------------------
	// Checks
	// --------------------
	// An unknown control or address on a pulse would load an unknown register
	a_ctrl_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(req.strobe) && (!req.strobe || !$isunknown({req.rd, req.addr}))
	);

endmodule

//--- lb_diag_status.sv
`timescale 1ns/1ns

module lb_diag_status (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             xdomain_fault,
	input  logic             tx_mac_done,
	input  logic [1:0]       rx_mac_buf_status,
	input  logic             tick,
	output lb_pkg::lb_diag_t diag
);

	logic [15:0] fault_count;
	logic [31:0] uptime;
	logic        tx_mac_done_r;
	logic [1:0]  rx_mac_buf_status_r;

	// --------------------
	// Counters
	// --------------------
	// Expect a burst of faults while the clock trees start up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_count <= '0;
			uptime      <= '0;
		end else begin
			if (xdomain_fault) begin
				fault_count <= fault_count + 1'b1;
			end
			if (tick) begin
				uptime <= uptime + 1'b1;
			end
		end
	end

	// MAC status into the bus clock domain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_mac_done_r       <= 1'b0;
			rx_mac_buf_status_r <= 2'b00;
		end else begin
			tx_mac_done_r       <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	assign diag = '{fault_count: fault_count, uptime: uptime,
		tx_mac_done: tx_mac_done_r, rx_buf_status: rx_mac_buf_status_r};

endmodule

//--- lb_macros.svh
`ifndef LB_MACROS_SVH
`define LB_MACROS_SVH

// Bus geometry
`define LB_ADDR_W 24
`define LB_DATA_W 32
`define LB_PAGE_W 8
`define LB_SUBPAGE_W 12

// Address pages and regions
`define LB_PAGE_LOCAL 8'h05
`define LB_PAGE_RXDATA 8'h03
`define LB_SUBPAGE_RXCNT 12'h041
`define LB_MISS_WORD 32'hdeadbeef

// ASCII words "Hell", "o wo", "rld!", "(::)"
`define LB_HELLO_0 32'h48656c6c
`define LB_HELLO_1 32'h6f20776f
`define LB_HELLO_2 32'h726c6421
`define LB_HELLO_3 32'h283a3a29

// Direct write offsets in the low five address bits
`define LB_REG_LED_USER 5'd1
`define LB_REG_LED1_DF 5'd2
`define LB_REG_LED2_DF 5'd3
`define LB_REG_RX_HBANK 5'd5
`define LB_REG_MISC 5'd8

// Block sizes
`define LB_LED_CW 10
`define LB_MIRROR_AW 5
`define LB_RXCNT_AW 4
`define LB_RXCNT_DW 20

`endif

//--- lb_mirror_ram.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module lb_mirror_ram (
	input  logic                  clk,
	input  lb_pkg::lb_req_t       req,
	input  logic                  we,
	output logic [`LB_DATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << `LB_MIRROR_AW;

	logic [`LB_DATA_W-1:0]   mem [0:DEPTH-1];
	logic [`LB_MIRROR_AW-1:0] ram_addr;

	// Same low address bits for both ports
	assign ram_addr = req.addr[`LB_MIRROR_AW-1:0];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[ram_addr] <= req.wdata;
		end
	end

	// Read port, lines up with read stage one
	always_ff @(posedge clk) begin
		rdata <= mem[ram_addr];
	end

endmodule

//--- lb_pkg.sv
`include "lb_macros.svh"

package lb_pkg;

	// --------------------
	// Local bus request, one cycle wide
	// --------------------
	typedef struct packed {
		logic [`LB_ADDR_W-1:0] addr;
		logic                  strobe;
		// High for a read, low for a write
		logic                  rd;
		logic [`LB_DATA_W-1:0] wdata;
	} lb_req_t;

	// --------------------
	// Direct-write configuration
	// --------------------
	typedef struct packed {
		logic [1:0] led_user_mode;
		logic [7:0] led1_df;
		logic [7:0] led2_df;
		// Receive buffer bank select
		logic       rx_mac_hbank;
		// Split onto board control pins at the top
		logic [7:0] misc_config;
	} lb_cfg_t;

	// --------------------
	// Read-only diagnostics
	// --------------------
	typedef struct packed {
		logic [15:0] fault_count;
		logic [31:0] uptime;
		// MAC status, already in the bus clock domain
		logic        tx_mac_done;
		logic [1:0]  rx_buf_status;
	} lb_diag_t;

endpackage

//--- lb_read_mux.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module lb_read_mux (
	input  logic                    clk,
	input  logic                    rst_n,
	input  lb_pkg::lb_req_t         req,
	input  lb_pkg::lb_diag_t        diag,
	input  logic [`LB_RXCNT_DW-1:0] rx_cnt_data,
	input  logic [`LB_DATA_W-1:0]   mirror_data,
	input  logic [15:0]             rx_mac_data,
	output logic [`LB_DATA_W-1:0]   rdata
);

	logic                       do_rd;
	logic                       do_rd_r;
	logic [`LB_ADDR_W-1:0]      addr_r;
	logic [`LB_DATA_W-1:0]      bank_word;
	logic [`LB_PAGE_W-1:0]      page_r;
	logic [`LB_SUBPAGE_W-1:0]   subpage_r;

	assign do_rd = req.strobe && req.rd;

	// --------------------
	// Stage one
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= req.addr;
	end

	// Bank slots 5 and 9 to f served removed functions and read zero
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (req.addr[3:0])
				4'h0: bank_word <= `LB_HELLO_0;
				4'h1: bank_word <= `LB_HELLO_1;
				4'h2: bank_word <= `LB_HELLO_2;
				4'h3: bank_word <= `LB_HELLO_3;
				4'h4: bank_word <= {16'h0000, diag.fault_count};
				4'h6: bank_word <= {31'h0, diag.tx_mac_done};
				4'h7: bank_word <= {30'h0, diag.rx_buf_status};
				4'h8: bank_word <= diag.uptime;
				default: bank_word <= '0;
			endcase
		end
	end

	// --------------------
	// Stage two
	// --------------------
	assign page_r    = addr_r[`LB_ADDR_W-1 -: `LB_PAGE_W];
	assign subpage_r = addr_r[`LB_ADDR_W-1 -: `LB_SUBPAGE_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (do_rd_r) begin
			if (page_r == '0 && addr_r[7:4] == 4'h0) begin
				rdata <= bank_word;
			end else if (page_r == `LB_PAGE_RXDATA) begin
				rdata <= {{(`LB_DATA_W-16){1'b0}}, rx_mac_data};
			end else if (subpage_r == `LB_SUBPAGE_RXCNT) begin
				rdata <= {{(`LB_DATA_W-`LB_RXCNT_DW){1'b0}}, rx_cnt_data};
			end else if (page_r == `LB_PAGE_LOCAL) begin
				rdata <= mirror_data;
			end else begin
				rdata <= `LB_MISS_WORD;
			end
		end
	end

	// Every source except the unreset mirror returns defined data
	a_rdata_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		(do_rd_r && page_r != `LB_PAGE_LOCAL) |=> !$isunknown(rdata)
	);

endmodule

//--- lb_slave_top.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module lb_slave_top #(
	parameter logic [7:0] misc_config_default = 8'h00
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`LB_ADDR_W-1:0] addr,
	input  logic                  control_strobe,
	input  logic                  control_rd,
	input  logic [`LB_DATA_W-1:0] data_out,
	input  logic                  xdomain_fault,
	input  logic                  tx_mac_done,
	input  logic [15:0]           rx_mac_data,
	input  logic [1:0]            rx_mac_buf_status,
	input  logic                  rx_category_s,
	input  logic [3:0]            rx_category,
	output logic [`LB_DATA_W-1:0] data_in,
	output logic                  rx_mac_hbank,
	output logic                  cfg_d02,
	output logic                  mmc_int,
	output logic                  allow_mmc_eth_config,
	output logic                  zest_pwr_en,
	output logic [3:0]            ext_config,
	output logic [1:0]            led_user_mode,
	output logic                  led1,
	output logic                  led2
);
	import lb_pkg::*;

	lb_req_t                  req;
	lb_cfg_t                  cfg;
	lb_diag_t                 diag;
	logic                     mirror_we;
	logic [`LB_DATA_W-1:0]    mirror_data;
	logic [`LB_RXCNT_DW-1:0]  rx_cnt_data;
	logic                     tick;

	assign req = '{addr: addr, strobe: control_strobe, rd: control_rd, wdata: data_out};

	lb_config_regs #(.misc_config_default(misc_config_default)) i_lb_config_regs (
		.clk(clk), .rst_n(rst_n), .req(req), .cfg(cfg), .mirror_we(mirror_we)
	);

	lb_mirror_ram i_lb_mirror_ram (
		.clk(clk), .req(req), .we(mirror_we), .rdata(mirror_data)
	);

	rx_category_counter i_rx_category_counter (
		.clk(clk), .rst_n(rst_n), .inc(rx_category_s), .inc_addr(rx_category),
		.read_addr(addr[`LB_RXCNT_AW-1:0]), .read_data(rx_cnt_data)
	);

	led_pwm i_led_pwm (
		.clk(clk), .rst_n(rst_n), .led1_df(cfg.led1_df), .led2_df(cfg.led2_df),
		.led1(led1), .led2(led2), .tick(tick)
	);

	lb_diag_status i_lb_diag_status (
		.clk(clk), .rst_n(rst_n), .xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done), .rx_mac_buf_status(rx_mac_buf_status),
		.tick(tick), .diag(diag)
	);

	lb_read_mux i_lb_read_mux (
		.clk(clk), .rst_n(rst_n), .req(req), .diag(diag), .rx_cnt_data(rx_cnt_data),
		.mirror_data(mirror_data), .rx_mac_data(rx_mac_data), .rdata(data_in)
	);

	// Board pins
	assign led_user_mode        = cfg.led_user_mode;
	assign rx_mac_hbank         = cfg.rx_mac_hbank;
	assign cfg_d02              = cfg.misc_config[0];
	assign mmc_int              = cfg.misc_config[1];
	assign allow_mmc_eth_config = cfg.misc_config[2];
	assign zest_pwr_en          = cfg.misc_config[3];
	assign ext_config           = cfg.misc_config[7:4];

endmodule

//--- led_pwm.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module led_pwm (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] led1_df,
	input  logic [7:0] led2_df,
	output logic       led1,
	output logic       led2,
	output logic       tick
);

	logic [`LB_LED_CW-1:0] led_cc;
	logic [`LB_LED_CW:0]   cc_next;
	logic [`LB_LED_CW-1:0] thresh1;
	logic [`LB_LED_CW-1:0] thresh2;

	// Carry out of the counter marks the wrap
	assign cc_next = {1'b0, led_cc} + 1'b1;

	// Duty factor in steps of four counts
	assign thresh1 = {led1_df, 2'b00};
	assign thresh2 = {led2_df, 2'b00};

	// --------------------
	// Counter and compare
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cc <= '0;
			tick   <= 1'b0;
			led1   <= 1'b0;
			led2   <= 1'b0;
		end else begin
			{tick, led_cc} <= cc_next;
			led1 <= (led_cc < thresh1);
			led2 <= (led_cc < thresh2);
		end
	end

endmodule

//--- rx_category_counter.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module rx_category_counter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    inc,
	input  logic [`LB_RXCNT_AW-1:0] inc_addr,
	input  logic [`LB_RXCNT_AW-1:0] read_addr,
	output logic [`LB_RXCNT_DW-1:0] read_data
);

	localparam int NCNT = 1 << `LB_RXCNT_AW;

	logic [`LB_RXCNT_DW-1:0] cnt [0:NCNT-1];

	// --------------------
	// Per-category counters
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NCNT; i++) begin
				cnt[i] <= '0;
			end
		end else if (inc) begin
			// Wraps silently at full scale
			cnt[inc_addr] <= cnt[inc_addr] + 1'b1;
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		read_data <= cnt[read_addr];
	end

	// A bad category index would corrupt an unknown counter
	a_inc_addr_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		inc |-> !$isunknown(inc_addr)
	);

endmodule

//--- tb_lb_slave.sv
`timescale 1ns/1ns
`include "lb_macros.svh"

module tb_lb_slave;

	localparam int clk_period = 100;
	localparam int pwm_window = 1 << `LB_LED_CW;
	// Rough cycle budget of each test
	localparam int config_cycles = 60;
	localparam int ident_cycles  = 40;
	localparam int mirror_cycles = 200;
	localparam int rxcnt_cycles  = 260;
	localparam int diag_cycles   = 2300;
	localparam int pwm_cycles    = 2200;
	localparam int watchdog_ns = (config_cycles + ident_cycles + mirror_cycles + rxcnt_cycles
		+ diag_cycles + pwm_cycles) * clk_period + 20000;

	logic                  clk;
	logic                  rst_n;
	logic [`LB_ADDR_W-1:0] addr;
	logic                  control_strobe;
	logic                  control_rd;
	logic [`LB_DATA_W-1:0] data_out;
	logic                  xdomain_fault;
	logic                  tx_mac_done;
	logic [15:0]           rx_mac_data;
	logic [1:0]            rx_mac_buf_status;
	logic                  rx_category_s;
	logic [3:0]            rx_category;
	logic [`LB_DATA_W-1:0] data_in;
	logic                  rx_mac_hbank;
	logic                  cfg_d02;
	logic                  mmc_int;
	logic                  allow_mmc_eth_config;
	logic                  zest_pwr_en;
	logic [3:0]            ext_config;
	logic [1:0]            led_user_mode;
	logic                  led1;
	logic                  led2;

	integer seed;
	int     n_pass;
	int     n_fail;
	int     fail_mark;

	// Reference model state
	logic [31:0] mirror_m [0:31];
	logic [19:0] rxcnt_m [0:15];
	logic [1:0]  led_user_m;
	logic [7:0]  led1_df_m;
	logic [7:0]  led2_df_m;
	logic        hbank_m;
	logic [7:0]  misc_m;
	logic [15:0] fault_m;
	logic        tx_done_m;
	logic [1:0]  buf_m;

	// Reads in flight with the oldest first
	logic [23:0] pend_addr [$];
	logic [31:0] pend_exp [$];
	bit          pend_chk [$];
	logic [31:0] last_rdata;

	lb_slave_top i_lb_slave_top (
		.clk(clk), .rst_n(rst_n), .addr(addr), .control_strobe(control_strobe),
		.control_rd(control_rd), .data_out(data_out), .xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done), .rx_mac_data(rx_mac_data),
		.rx_mac_buf_status(rx_mac_buf_status), .rx_category_s(rx_category_s),
		.rx_category(rx_category), .data_in(data_in), .rx_mac_hbank(rx_mac_hbank),
		.cfg_d02(cfg_d02), .mmc_int(mmc_int), .allow_mmc_eth_config(allow_mmc_eth_config),
		.zest_pwr_en(zest_pwr_en), .ext_config(ext_config), .led_user_mode(led_user_mode),
		.led1(led1), .led2(led2)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// --------------------
	// Reference model
	// --------------------
	function automatic logic [31:0] lb_expect(input logic [23:0] a);
		logic [31:0] e;
		if (a[23:16] == 8'h00 && a[7:4] == 4'h0) begin
			case (a[3:0])
				4'h0: e = `LB_HELLO_0;
				4'h1: e = `LB_HELLO_1;
				4'h2: e = `LB_HELLO_2;
				4'h3: e = `LB_HELLO_3;
				4'h4: e = {16'h0, fault_m};
				4'h6: e = {31'h0, tx_done_m};
				4'h7: e = {30'h0, buf_m};
				// Uptime is checked only by its growth
				default: e = 32'h0;
			endcase
		end else if (a[23:16] == `LB_PAGE_RXDATA) begin
			e = {16'h0, rx_mac_data};
		end else if (a[23:12] == `LB_SUBPAGE_RXCNT) begin
			e = {12'h0, rxcnt_m[a[3:0]]};
		end else if (a[23:16] == `LB_PAGE_LOCAL) begin
			e = mirror_m[a[4:0]];
		end else begin
			e = `LB_MISS_WORD;
		end
		return e;
	endfunction

	function automatic void model_write(input logic [23:0] a, input logic [31:0] d);
		if (a[23:16] == `LB_PAGE_LOCAL) begin
			mirror_m[a[4:0]] = d;
			case (a[4:0])
				`LB_REG_LED_USER: led_user_m = d[1:0];
				`LB_REG_LED1_DF: led1_df_m = d[7:0];
				`LB_REG_LED2_DF: led2_df_m = d[7:0];
				`LB_REG_RX_HBANK: hbank_m = d[0];
				`LB_REG_MISC: misc_m = d[7:0];
				default: ;
			endcase
		end
	endfunction

	// --------------------
	// Bus tasks and checks
	// --------------------
	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		@(posedge clk);
		addr <= a;
		data_out <= d;
		control_strobe <= 1'b1;
		control_rd <= 1'b0;
		@(posedge clk);
		control_strobe <= 1'b0;
		model_write(a, d);
	endtask

	// Leaves the pulse up so that the next read can follow directly
	task automatic issue_read(input logic [23:0] a, input bit chk);
		@(posedge clk);
		addr <= a;
		control_strobe <= 1'b1;
		control_rd <= 1'b1;
		pend_addr.push_back(a);
		pend_exp.push_back(lb_expect(a));
		pend_chk.push_back(chk);
	endtask

	task automatic finish_reads;
		@(posedge clk);
		control_strobe <= 1'b0;
		control_rd <= 1'b0;
		while (pend_exp.size() != 0) @(negedge clk);
	endtask

	task automatic compare_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_pins;
		compare_word("led_user_mode", {30'h0, led_user_m}, {30'h0, led_user_mode});
		compare_word("rx_mac_hbank", {31'h0, hbank_m}, {31'h0, rx_mac_hbank});
		compare_word("cfg_d02", {31'h0, misc_m[0]}, {31'h0, cfg_d02});
		compare_word("mmc_int", {31'h0, misc_m[1]}, {31'h0, mmc_int});
		compare_word("allow_mmc_eth_config", {31'h0, misc_m[2]}, {31'h0, allow_mmc_eth_config});
		compare_word("zest_pwr_en", {31'h0, misc_m[3]}, {31'h0, zest_pwr_en});
		compare_word("ext_config", {28'h0, misc_m[7:4]}, {28'h0, ext_config});
	endtask

	task automatic end_test(input string name);
		if (n_fail == fail_mark)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d errors", name, n_fail - fail_mark);
		fail_mark = n_fail;
	endtask

	// Read data is due two edges after its read pulse
	initial begin : compare_reads
		bit          stage1;
		bit          stage2;
		logic [23:0] a;
		logic [31:0] e;
		bit          c;
		stage1 = 1'b0;
		stage2 = 1'b0;
		forever begin
			@(negedge clk);
			if (stage2) begin
				if (pend_exp.size() == 0) begin
					$display("FAILED at %0t ns: a read completed that no task issued", $time);
					n_fail++;
				end else begin
					a = pend_addr.pop_front();
					e = pend_exp.pop_front();
					c = pend_chk.pop_front();
					last_rdata = data_in;
					if (c)
						compare_word($sformatf("data_in at %h", a), e, data_in);
				end
			end
			stage2 = stage1;
			stage1 = control_strobe && control_rd;
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Run timed out after %0d ns with a test still waiting", watchdog_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin : main
		bit          s;
		logic [3:0]  cat;
		logic [31:0] u0;
		logic [31:0] u1;
		logic [7:0]  df1;
		logic [7:0]  df2;
		int          high1;
		int          high2;
		seed = 32'h3fb5;
		n_pass = 0;
		n_fail = 0;
		fail_mark = 0;
		led_user_m = 2'b00;
		led1_df_m = 8'h00;
		led2_df_m = 8'h00;
		hbank_m = 1'b1;
		misc_m = 8'h00;
		fault_m = 16'h0;
		tx_done_m = 1'b0;
		buf_m = 2'b00;
		for (int i = 0; i < 16; i++)
			rxcnt_m[i] = 20'h0;
		rst_n <= 1'b0;
		addr <= '0;
		control_strobe <= 1'b0;
		control_rd <= 1'b0;
		data_out <= '0;
		xdomain_fault <= 1'b0;
		tx_mac_done <= 1'b0;
		rx_mac_data <= 16'h0;
		rx_mac_buf_status <= 2'b00;
		rx_category_s <= 1'b0;
		rx_category <= 4'h0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Reset values before any register write
		@(negedge clk);
		compare_word("data_in", 32'h0, data_in);
		compare_word("led1", 32'h0, {31'h0, led1});
		compare_word("led2", 32'h0, {31'h0, led2});
		check_pins;
		for (int r = 0; r < 4; r++) begin
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_LED_USER}, $random(seed));
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_LED1_DF}, $random(seed));
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_LED2_DF}, $random(seed));
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_RX_HBANK}, $random(seed));
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_MISC}, $random(seed));
			@(negedge clk);
			check_pins;
		end
		end_test("config");

		rx_mac_data <= $random(seed);
		for (int i = 0; i < 4; i++)
			issue_read(24'(i), 1'b1);
		issue_read(24'h000005, 1'b1);
		issue_read(24'h7a0000, 1'b1);
		issue_read(24'h000010, 1'b1);
		issue_read({`LB_PAGE_RXDATA, 16'h0}, 1'b1);
		finish_reads;
		end_test("ident");

		for (int i = 0; i < 32; i++)
			bus_write({`LB_PAGE_LOCAL, 16'(i)}, $random(seed));
		for (int i = 0; i < 32; i++)
			issue_read({`LB_PAGE_LOCAL, 16'(i)}, 1'b1);
		finish_reads;
		check_pins;
		end_test("mirror");

		for (int i = 0; i < 200; i++) begin
			@(posedge clk);
			s = $random(seed);
			cat = $random(seed);
			rx_category_s <= s;
			rx_category <= cat;
			if (s)
				rxcnt_m[cat] = rxcnt_m[cat] + 1'b1;
		end
		@(posedge clk);
		rx_category_s <= 1'b0;
		for (int i = 0; i < 16; i++)
			issue_read({`LB_SUBPAGE_RXCNT, 8'h00, 4'(i)}, 1'b1);
		finish_reads;
		end_test("rx_counters");

		for (int i = 0; i < 100; i++) begin
			@(posedge clk);
			s = $random(seed);
			xdomain_fault <= s;
			if (s)
				fault_m = fault_m + 1'b1;
		end
		@(posedge clk);
		xdomain_fault <= 1'b0;
		tx_done_m = $random(seed);
		buf_m = $random(seed);
		tx_mac_done <= tx_done_m;
		rx_mac_buf_status <= buf_m;
		repeat (2) @(posedge clk);
		issue_read(24'h000004, 1'b1);
		issue_read(24'h000006, 1'b1);
		issue_read(24'h000007, 1'b1);
		issue_read(24'h000008, 1'b0);
		finish_reads;
		u0 = last_rdata;
		// Two PWM wraps between the uptime reads
		repeat (2 * pwm_window) @(posedge clk);
		issue_read(24'h000008, 1'b0);
		finish_reads;
		u1 = last_rdata;
		if (u1 - u0 != 2 && u1 - u0 != 3) begin
			$display("FAILED at %0t ns: uptime growth expected 2 or 3 actual %0d", $time, u1 - u0);
			n_fail++;
		end else begin
			n_pass++;
		end
		// Inverted levels so that each status bit is seen at both values
		tx_done_m = ~tx_done_m;
		buf_m = ~buf_m;
		tx_mac_done <= tx_done_m;
		rx_mac_buf_status <= buf_m;
		repeat (2) @(posedge clk);
		issue_read(24'h000006, 1'b1);
		issue_read(24'h000007, 1'b1);
		finish_reads;
		end_test("diagnostics");

		for (int r = 0; r < 2; r++) begin
			df1 = $random(seed);
			df2 = $random(seed);
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_LED1_DF}, {24'h0, df1});
			bus_write({`LB_PAGE_LOCAL, 11'h0, `LB_REG_LED2_DF}, {24'h0, df2});
			repeat (2) @(posedge clk);
			high1 = 0;
			high2 = 0;
			repeat (pwm_window) begin
				@(negedge clk);
				if (led1)
					high1++;
				if (led2)
					high2++;
			end
			compare_word("led1 high cycles", 4 * led1_df_m, high1);
			compare_word("led2 high cycles", 4 * led2_df_m, high2);
		end
		end_test("pwm");

		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
lb_pkg.sv
lb_config_regs.sv
lb_mirror_ram.sv
led_pwm.sv
rx_category_counter.sv
lb_diag_status.sv
lb_read_mux.sv
lb_slave_top.sv
tb_lb_slave.sv
